// File: all.f
hw/mem_pkg.sv
hw/req_queue.sv
hw/byte_packer.sv
hw/mem_ctrl.sv
hw/mem_subsys.sv
verification/byte_ram_model.sv
verification/tb_mem_subsys.sv

// File: hw/byte_packer.sv
///////////////////////////////
// byte packer, gathers read bytes
// into a word and extends it
///////////////////////////////
`timescale 1ns/10ps

module byte_packer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       capture,
    input  logic                       finish,
    input  logic [1:0]                 byte_idx,
    input  logic [7:0]                 mem_din,
    input  logic [mem_pkg::LEN_W-1:0]  len,
    input  logic                       is_unsigned,
    output logic [mem_pkg::DATA_W-1:0] word
);

    logic [mem_pkg::DATA_W-1:0] hold;
    logic [mem_pkg::DATA_W-1:0] hold_nxt;
    logic [mem_pkg::DATA_W-1:0] ext;
    logic                       sign_b;
    logic                       sign_h;

    // merge the incoming byte into its lane
    always_comb begin
        hold_nxt = hold;
        if (capture) begin
            // byte 0 starts a new transfer
            if (byte_idx == 2'd0) hold_nxt = '0;
            hold_nxt[{byte_idx, 3'b000} +: 8] = mem_din;
        end
    end

    assign sign_b = !is_unsigned && hold_nxt[7];
    assign sign_h = !is_unsigned && hold_nxt[15];

    // sign or zero extension by length code
    always_comb begin
        case (len)
            mem_pkg::LEN_BYTE: begin
                ext = {{(mem_pkg::DATA_W - 8){sign_b}}, hold_nxt[7:0]};
            end
            mem_pkg::LEN_HALF: begin
                ext = {{(mem_pkg::DATA_W - 16){sign_h}}, hold_nxt[15:0]};
            end
            default: begin
                ext = hold_nxt;
            end
        endcase
    end

    // finish lands on the capture of the last byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold <= '0;
            word <= '0;
        end else begin
            if (capture) hold <= hold_nxt;
            if (finish) word <= ext;
        end
    end

    // the last byte is always captured together with finish
    a_finish_capture: assert property (@(posedge clk) disable iff (!rst_n)
        finish |-> capture);

endmodule

// File: hw/mem_ctrl.sv
///////////////////////////////
// memory controller, arbitrates fetch and
// load/store and moves bytes over the bus
///////////////////////////////
`timescale 1ns/10ps

module mem_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rdy,
    input  logic                       clr,
    input  logic                       io_buffer_full,
    input  logic                       ls_head_valid,
    input  mem_pkg::ls_req_t           ls_head,
    input  logic                       fetch_head_valid,
    input  mem_pkg::fetch_req_t        fetch_head,
    output logic                       ls_pop,
    output logic                       fetch_pop,
    output logic [mem_pkg::ADDR_W-1:0] mem_a,
    output logic [7:0]                 mem_dout,
    output logic                       mem_wr,
    output logic                       capture,
    output logic                       finish,
    output logic [1:0]                 byte_idx,
    output logic [mem_pkg::LEN_W-1:0]  len,
    output logic                       is_unsigned,
    input  logic [mem_pkg::DATA_W-1:0] packed_word,
    output logic                       fetch_done,
    output logic [mem_pkg::DATA_W-1:0] fetch_inst,
    output logic                       ls_done,
    output logic [mem_pkg::NICK_W-1:0] ls_done_nick,
    output logic [mem_pkg::DATA_W-1:0] ls_done_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_DRAIN
    } state_t;

    state_t                     state;
    logic [1:0]                 cnt;
    logic                       cur_fetch;
    logic                       cur_store;
    logic                       cancel;
    logic                       rd_pend;
    logic [1:0]                 cap_idx;
    logic                       fetch_done_q;
    logic                       ls_done_q;

    // latched request payload
    logic [mem_pkg::ADDR_W-1:0] cur_addr;
    logic [mem_pkg::DATA_W-1:0] cur_data;
    logic [mem_pkg::LEN_W-1:0]  cur_len;
    logic                       cur_unsigned;
    logic [mem_pkg::NICK_W-1:0] cur_nick;

    logic                       take_ls;
    logic                       take_fetch;
    logic                       io_hold;
    logic                       byte_ok;
    logic                       last_byte;

    // load/store wins over fetch, nothing is taken while paused
    assign take_ls    = (state == ST_IDLE) && rdy && ls_head_valid;
    assign take_fetch = (state == ST_IDLE) && rdy && !ls_head_valid &&
                        fetch_head_valid && !clr;
    assign ls_pop     = take_ls;
    assign fetch_pop  = take_fetch;

    // uart writes wait for room in the output buffer
    assign io_hold   = cur_store && mem_pkg::is_io(cur_addr) && io_buffer_full;
    assign byte_ok   = (state == ST_ISSUE) && rdy && !io_hold;
    assign last_byte = (cnt == mem_pkg::last_idx(cur_len));

    assign mem_a    = byte_ok ? cur_addr : '0;
    assign mem_dout = cur_data[7:0];
    assign mem_wr   = byte_ok && cur_store;

    // read data returns one cycle after its address
    assign capture     = rd_pend;
    assign byte_idx    = cap_idx;
    assign finish      = (state == ST_DRAIN);
    assign len         = cur_len;
    assign is_unsigned = cur_unsigned;

    // a done in the flush cycle belongs to a cancelled fetch
    assign fetch_done   = fetch_done_q && !clr;
    assign fetch_inst   = packed_word;
    assign ls_done      = ls_done_q;
    assign ls_done_nick = cur_nick;
    assign ls_done_data = cur_store ? '0 : packed_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            cnt          <= '0;
            cur_fetch    <= 1'b0;
            cur_store    <= 1'b0;
            cancel       <= 1'b0;
            rd_pend      <= 1'b0;
            cap_idx      <= '0;
            fetch_done_q <= 1'b0;
            ls_done_q    <= 1'b0;
        end else begin
            fetch_done_q <= 1'b0;
            ls_done_q    <= 1'b0;
            rd_pend      <= byte_ok && !cur_store;
            if (byte_ok) cap_idx <= cnt;

            case (state)
                ST_IDLE: begin
                    if (take_ls || take_fetch) begin
                        state     <= ST_ISSUE;
                        cnt       <= '0;
                        cancel    <= 1'b0;
                        cur_fetch <= take_fetch;
                        cur_store <= take_ls && ls_head.is_store;
                    end
                end
                ST_ISSUE: begin
                    if (byte_ok) begin
                        if (!last_byte) begin
                            cnt <= cnt + 1'b1;
                        end else if (cur_store) begin
                            // writes finish with their last byte
                            state     <= ST_IDLE;
                            ls_done_q <= 1'b1;
                        end else begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    state <= ST_IDLE;
                    if (cur_fetch) fetch_done_q <= !(cancel || clr);
                    else ls_done_q <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // flush hits a fetch already past its pop
            if (clr && (state != ST_IDLE) && cur_fetch) cancel <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take_ls) begin
            cur_addr     <= ls_head.addr;
            cur_data     <= ls_head.data;
            cur_len      <= ls_head.len;
            cur_unsigned <= ls_head.is_unsigned;
            cur_nick     <= ls_head.nick;
        end else if (take_fetch) begin
            cur_addr     <= fetch_head.pc;
            cur_data     <= '0;
            cur_len      <= mem_pkg::LEN_WORD;
            cur_unsigned <= 1'b1;
        end else if (byte_ok) begin
            // step to the next byte, little endian
            cur_addr <= cur_addr + 1'b1;
            cur_data <= cur_data >> 8;
        end
    end

    // a paused transfer keeps its byte pending
    a_no_wr_paused: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == ST_ISSUE) && !rdy) |=>
            ((state == ST_ISSUE) && $stable(cnt) && $stable(cur_addr)));

    // a held uart byte stays pending until the buffer has room
    a_io_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == ST_ISSUE) && io_hold) |=>
            ((state == ST_ISSUE) && $stable(cnt) && $stable(cur_addr)));

endmodule

// File: hw/mem_pkg.sv
///////////////////////////////
// memory subsystem shared widths, length codes
// and request payload types
///////////////////////////////

package mem_pkg;

    // bus and word widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int NICK_W = 4;
    localparam int LEN_W  = 2;

    // length codes, bytes moved is code + 1 except for a word
    localparam logic [LEN_W-1:0] LEN_BYTE = 2'd0;
    localparam logic [LEN_W-1:0] LEN_HALF = 2'd1;
    localparam logic [LEN_W-1:0] LEN_WORD = 2'd2;

    // addr[17:16] selects the uart window
    localparam logic [1:0] IO_SEL = 2'b11;

    // queue depths
    localparam int LS_DEPTH    = 4;
    localparam int FETCH_DEPTH = 2;

    // load/store request from the store/load buffer
    typedef struct packed {
        logic              is_store;
        logic              is_unsigned;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [NICK_W-1:0] nick;
    } ls_req_t;

    // instruction fetch request
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
    } fetch_req_t;

    // true for an address inside the i/o window
    function automatic logic is_io(input logic [ADDR_W-1:0] addr);
        return addr[17:16] == IO_SEL;
    endfunction

    // index of the final byte for a length code
    function automatic logic [1:0] last_idx(input logic [LEN_W-1:0] len);
        logic [1:0] idx;
        idx = (len == LEN_WORD) ? 2'd3 : len;
        return idx;
    endfunction

endpackage

// File: hw/mem_subsys.sv
///////////////////////////////
// memory subsystem top, request queues,
// controller and byte packer on the bus
///////////////////////////////
`timescale 1ns/10ps

module mem_subsys (
    input  logic                       clk_in,
    input  logic                       rst_n,
    input  logic                       rdy_in,
    input  logic                       clr,

    input  logic [7:0]                 mem_din,
    output logic [7:0]                 mem_dout,
    output logic [mem_pkg::ADDR_W-1:0] mem_a,
    output logic                       mem_wr,
    input  logic                       io_buffer_full,

    input  logic                       fetch_en,
    input  logic [mem_pkg::ADDR_W-1:0] fetch_pc,
    output logic                       fetch_full,
    output logic                       fetch_done,
    output logic [mem_pkg::DATA_W-1:0] fetch_inst,

    input  logic                       ls_en,
    input  logic                       ls_store,
    input  logic                       ls_unsigned,
    input  logic [mem_pkg::LEN_W-1:0]  ls_len,
    input  logic [mem_pkg::ADDR_W-1:0] ls_addr,
    input  logic [mem_pkg::DATA_W-1:0] ls_data,
    input  logic [mem_pkg::NICK_W-1:0] ls_nick,
    output logic                       ls_full,
    output logic                       ls_done,
    output logic [mem_pkg::NICK_W-1:0] ls_done_nick,
    output logic [mem_pkg::DATA_W-1:0] ls_done_data
);

    mem_pkg::fetch_req_t        fetch_push_item;
    mem_pkg::fetch_req_t        fetch_head;
    logic                       fetch_head_valid;
    logic                       fetch_pop;

    mem_pkg::ls_req_t           ls_push_item;
    mem_pkg::ls_req_t           ls_head;
    logic                       ls_head_valid;
    logic                       ls_pop;

    logic                       capture;
    logic                       finish;
    logic [1:0]                 byte_idx;
    logic [mem_pkg::LEN_W-1:0]  pk_len;
    logic                       pk_unsigned;
    logic [mem_pkg::DATA_W-1:0] packed_word;

    assign fetch_push_item = '{pc: fetch_pc};
    assign ls_push_item    = '{is_store:    ls_store,
                               is_unsigned: ls_unsigned,
                               len:         ls_len,
                               addr:        ls_addr,
                               data:        ls_data,
                               nick:        ls_nick};

    // fetch queue, emptied by flush
    req_queue #(
        .item_t (mem_pkg::fetch_req_t),
        .DEPTH  (mem_pkg::FETCH_DEPTH)
    ) i_fetch_q (
        .clk        (clk_in),
        .rst_n      (rst_n),
        .clr        (clr),
        .push       (fetch_en),
        .push_item  (fetch_push_item),
        .pop        (fetch_pop),
        .head_valid (fetch_head_valid),
        .head_item  (fetch_head),
        .full       (fetch_full)
    );

    // load/store queue survives a flush
    req_queue #(
        .item_t (mem_pkg::ls_req_t),
        .DEPTH  (mem_pkg::LS_DEPTH)
    ) i_ls_q (
        .clk        (clk_in),
        .rst_n      (rst_n),
        .clr        (1'b0),
        .push       (ls_en),
        .push_item  (ls_push_item),
        .pop        (ls_pop),
        .head_valid (ls_head_valid),
        .head_item  (ls_head),
        .full       (ls_full)
    );

    mem_ctrl i_mem_ctrl (
        .clk              (clk_in),
        .rst_n            (rst_n),
        .rdy              (rdy_in),
        .clr              (clr),
        .io_buffer_full   (io_buffer_full),
        .ls_head_valid    (ls_head_valid),
        .ls_head          (ls_head),
        .fetch_head_valid (fetch_head_valid),
        .fetch_head       (fetch_head),
        .ls_pop           (ls_pop),
        .fetch_pop        (fetch_pop),
        .mem_a            (mem_a),
        .mem_dout         (mem_dout),
        .mem_wr           (mem_wr),
        .capture          (capture),
        .finish           (finish),
        .byte_idx         (byte_idx),
        .len              (pk_len),
        .is_unsigned      (pk_unsigned),
        .packed_word      (packed_word),
        .fetch_done       (fetch_done),
        .fetch_inst       (fetch_inst),
        .ls_done          (ls_done),
        .ls_done_nick     (ls_done_nick),
        .ls_done_data     (ls_done_data)
    );

    byte_packer i_byte_packer (
        .clk         (clk_in),
        .rst_n       (rst_n),
        .capture     (capture),
        .finish      (finish),
        .byte_idx    (byte_idx),
        .mem_din     (mem_din),
        .len         (pk_len),
        .is_unsigned (pk_unsigned),
        .word        (packed_word)
    );

endmodule

// File: hw/req_queue.sv
///////////////////////////////
// request queue, circular buffer
// with a payload type parameter
///////////////////////////////
`timescale 1ns/10ps

module req_queue #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clr,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output logic  head_valid,
    output item_t head_item,
    output logic  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign full       = (count == CNT_W'(DEPTH));
    assign head_item  = mem[rd_ptr];
    assign do_push    = push && !full;
    assign do_pop     = pop && head_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr) begin
            // flush drops everything, including a same-cycle push
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !clr) mem[wr_ptr] <= push_item;
    end

    // the core must hold its enable while the queue is full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

    // the controller only pops a head it has seen valid
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

endmodule

// File: verification/byte_ram_model.sv
///////////////////////////////
// byte ram model, 128 KB with one cycle
// read latency and a uart output log
///////////////////////////////
`timescale 1ns/10ps

module byte_ram_model (
    input  logic                       clk_in,
    input  logic [mem_pkg::ADDR_W-1:0] mem_a,
    input  logic [7:0]                 mem_dout,
    input  logic                       mem_wr,
    input  logic                       rdy_in,
    input  logic                       io_stall_en,
    output logic [7:0]                 mem_din,
    output logic                       io_buffer_full
);

    logic [7:0] mem [2**17];
    logic [7:0] io_log [$];
    integer     seed;
    int         wr_paused;
    int         wr_io_full;
    logic       io_hit;

    assign io_hit = (mem_a[17:16] == mem_pkg::IO_SEL);

    initial begin
        seed           = 19;
        wr_paused      = 0;
        wr_io_full     = 0;
        mem_din        = 8'h00;
        io_buffer_full = 1'b0;
        // fill pattern mixes all 17 address bits
        for (int i = 0; i < 2**17; i++) begin
            mem[i] = 8'((i * 157) ^ (i >> 8) ^ ((i >> 16) * 8'h55));
        end
    end

    always @(posedge clk_in) begin
        if (mem_wr) begin
            if (!rdy_in) wr_paused++;
            if (io_hit && io_buffer_full) wr_io_full++;
            if (io_hit) io_log.push_back(mem_dout);
            else mem[mem_a[16:0]] = mem_dout;
        end
        // read data shows up one cycle after its address
        mem_din <= #1 io_hit ? 8'h00 : mem[mem_a[16:0]];
        // uart side drains at random
        if (io_stall_en) io_buffer_full <= #1 1'($random(seed));
        else io_buffer_full <= #1 1'b0;
    end

endmodule

// File: verification/tb_mem_subsys.sv
///////////////////////////////
// memory subsystem testbench, random
// traffic checked against a byte mirror
///////////////////////////////
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam int N_ST    = 24;
    localparam int N_FETCH = 16;
    localparam int N_MIX   = 40;
    localparam int N_IO    = 16;
    localparam int N_CLR   = 6;
    // 40 cycles for each issued request
    localparam int CYCLE_LIMIT = 40 * (2 * N_ST + N_FETCH + 2 * N_MIX + N_IO + N_CLR + 3);

    logic                       clk_in;
    logic                       rst_n;
    logic                       rdy_in;
    logic                       clr;
    logic [7:0]                 mem_din;
    logic [7:0]                 mem_dout;
    logic [mem_pkg::ADDR_W-1:0] mem_a;
    logic                       mem_wr;
    logic                       io_buffer_full;
    logic                       io_stall_en;
    logic                       fetch_en;
    logic [mem_pkg::ADDR_W-1:0] fetch_pc;
    logic                       fetch_full;
    logic                       fetch_done;
    logic [mem_pkg::DATA_W-1:0] fetch_inst;
    logic                       ls_en;
    logic                       ls_store;
    logic                       ls_unsigned;
    logic [mem_pkg::LEN_W-1:0]  ls_len;
    logic [mem_pkg::ADDR_W-1:0] ls_addr;
    logic [mem_pkg::DATA_W-1:0] ls_data;
    logic [mem_pkg::NICK_W-1:0] ls_nick;
    logic                       ls_full;
    logic                       ls_done;
    logic [mem_pkg::NICK_W-1:0] ls_done_nick;
    logic [mem_pkg::DATA_W-1:0] ls_done_data;

    // reference model state
    logic [7:0]  mirror [2**17];
    logic [35:0] ls_exp [$];
    logic [31:0] fetch_exp [$];
    logic [7:0]  io_exp [$];
    logic [31:0] st_addr [N_ST];
    logic [35:0] exp_ls;
    logic [31:0] exp_word;
    integer      seed;
    int          errors;
    int          checks;
    int          err_base;
    int          cycles;
    logic        pause_en;

    mem_subsys i_dut (.*);

    byte_ram_model i_ram (.*);

    always #4 clk_in = ~clk_in;

    // little endian word from the mirror, extended by length code
    function automatic logic [31:0] load_value(input logic [16:0] a, input logic [1:0] len,
                                               input logic uns);
        logic [31:0] w;
        w = {mirror[a + 3], mirror[a + 2], mirror[a + 1], mirror[a]};
        if (len == mem_pkg::LEN_BYTE) w = uns ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
        if (len == mem_pkg::LEN_HALF) w = uns ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
        return w;
    endfunction

    // fetches stay in the upper half, stores never touch it
    function automatic logic [31:0] fetch_addr();
        return 32'h10000 | (32'($random(seed)) & 32'hfffc);
    endfunction

    task automatic tick();
        @(posedge clk_in);
        #1;
        rdy_in = pause_en ? (($random(seed) & 3) != 0) : 1'b1;
    endtask

    task automatic push_ls(input logic st, input logic uns, input logic [1:0] len,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] nick);
        int n;
        n = (len == mem_pkg::LEN_WORD) ? 4 : len + 1;
        while (ls_full) tick();
        ls_en       = 1'b1;
        ls_store    = st;
        ls_unsigned = uns;
        ls_len      = len;
        ls_addr     = addr;
        ls_data     = data;
        ls_nick     = nick;
        if (!st) begin
            ls_exp.push_back({nick, load_value(addr[16:0], len, uns)});
        end else begin
            ls_exp.push_back({nick, 32'h0});
            // uart writes leave memory alone
            for (int k = 0; k < n && addr[17:16] != mem_pkg::IO_SEL; k++) begin
                mirror[addr[16:0] + k] = data[8 * k +: 8];
            end
        end
        tick();
        ls_en = 1'b0;
    endtask

    task automatic push_fetch(input logic [31:0] pc);
        while (fetch_full) tick();
        fetch_en = 1'b1;
        fetch_pc = pc;
        fetch_exp.push_back(load_value(pc[16:0], mem_pkg::LEN_WORD, 1'b1));
        tick();
        fetch_en = 1'b0;
    endtask

    // one random request, about a quarter of them fetches
    task automatic mixed_step();
        logic [31:0] r;
        r = $random(seed);
        if (r[9:8] == 2'b00) push_fetch(fetch_addr());
        else push_ls(r[0], r[1], 2'(r[3:2] % 3), {20'h0, r[31:20]}, $random(seed), r[7:4]);
    endtask

    task automatic wait_idle();
        while (ls_exp.size() != 0 || fetch_exp.size() != 0) tick();
        // room for a stray done pulse
        repeat (3) tick();
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    // every done pulse is matched against the expected queues
    always @(posedge clk_in) begin
        if (rst_n && ls_done) begin
            checks++;
            assert (ls_exp.size() != 0) else begin
                $display("ls_done at %0d ns with no load or store outstanding", $time);
                errors++;
            end
            if (ls_exp.size() != 0) begin
                exp_ls = ls_exp.pop_front();
                assert ({ls_done_nick, ls_done_data} == exp_ls) else begin
                    $display("Mismatch at %0d ns: nick %0d data %h, expected nick %0d data %h",
                             $time, ls_done_nick, ls_done_data, exp_ls[35:32], exp_ls[31:0]);
                    errors++;
                end
            end
        end
        if (rst_n && fetch_done) begin
            checks++;
            assert (fetch_exp.size() != 0) else begin
                $display("fetch_done at %0d ns with no fetch outstanding", $time);
                errors++;
            end
            if (fetch_exp.size() != 0) begin
                exp_word = fetch_exp.pop_front();
                assert (fetch_inst == exp_word) else begin
                    $display("Mismatch at %0d ns: fetch_inst %h, expected %h",
                             $time, fetch_inst, exp_word);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        seed        = 19;
        errors      = 0;
        checks      = 0;
        err_base    = 0;
        cycles      = 0;
        pause_en    = 1'b0;
        clk_in      = 1'b0;
        rst_n       = 1'b0;
        rdy_in      = 1'b1;
        clr         = 1'b0;
        io_stall_en = 1'b0;
        fetch_en    = 1'b0;
        fetch_pc    = '0;
        ls_en       = 1'b0;
        ls_store    = 1'b0;
        ls_unsigned = 1'b0;
        ls_len      = '0;
        ls_addr     = '0;
        ls_data     = '0;
        ls_nick     = '0;
        repeat (4) @(posedge clk_in);
        // mirror starts from the model's memory image
        for (int i = 0; i < 2**17; i++) mirror[i] = i_ram.mem[i];
        #1;
        rst_n = 1'b1;
        tick();

        // stores of every length, then loads of the same addresses
        for (int i = 0; i < N_ST; i++) begin
            st_addr[i] = 32'($random(seed)) & 32'hfff;
            push_ls(1'b1, 1'b0, 2'(i % 3), st_addr[i], $random(seed), 4'(i));
        end
        for (int i = 0; i < N_ST; i++) begin
            push_ls(1'b0, 1'($random(seed)), 2'(i % 3), st_addr[i], 32'h0, 4'(i));
        end
        wait_idle();
        finish_test("store then load");

        repeat (N_FETCH) push_fetch(fetch_addr());
        wait_idle();
        finish_test("fetch");

        repeat (N_MIX) mixed_step();
        wait_idle();
        finish_test("mixed traffic");

        pause_en = 1'b1;
        repeat (N_MIX) mixed_step();
        wait_idle();
        pause_en = 1'b0;
        checks++;
        assert (i_ram.wr_paused == 0) else begin
            $display("memory written %0d times while rdy_in was low", i_ram.wr_paused);
            errors++;
        end
        finish_test("rdy_in pauses");

        io_stall_en = 1'b1;
        for (int i = 0; i < N_IO; i++) begin
            io_exp.push_back(8'($random(seed)));
            push_ls(1'b1, 1'b0, mem_pkg::LEN_BYTE, 32'h30000, {24'h0, io_exp[i]}, 4'(i));
        end
        wait_idle();
        io_stall_en = 1'b0;
        checks++;
        assert (i_ram.wr_io_full == 0 && i_ram.io_log.size() == N_IO) else begin
            $display("uart got %0d bytes, %0d of them while io_buffer_full was high",
                     i_ram.io_log.size(), i_ram.wr_io_full);
            errors++;
        end
        for (int i = 0; i < N_IO && i < i_ram.io_log.size(); i++) begin
            checks++;
            assert (i_ram.io_log[i] == io_exp[i]) else begin
                $display("Mismatch at %0d ns: uart byte %0d is %h, expected %h",
                         $time, i, i_ram.io_log[i], io_exp[i]);
                errors++;
            end
        end
        finish_test("uart writes");

        // flush with one fetch in flight and two queued
        repeat (3) push_fetch(fetch_addr());
        clr = 1'b1;
        fetch_exp.delete();
        tick();
        clr = 1'b0;
        repeat (N_CLR) push_fetch(fetch_addr());
        wait_idle();
        finish_test("flush");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
